//--- filelist.f
hw/mem_bus_pkg.sv
hw/mem_addr_decoder.sv
hw/byte_sequencer.sv
hw/read_word_assembler.sv
hw/byte_ram.sv
hw/hex_display_regs.sv
hw/test_pass_regs.sv
hw/mem_bus_top.sv
tests/mem_bus_tb.sv

//--- hw/byte_ram.sv
`timescale 1ns/100ps

module byte_ram #(
  parameter int ADDR_W = 12
) (
  input  logic                   i_clk,
  input  logic [ADDR_W-1:0]      i_addr,
  input  mem_bus_pkg::bus_byte_t i_wr_byte,
  input  logic                   i_write,
  input  logic                   i_req,
  output mem_bus_pkg::bus_byte_t o_rd_byte,
  output logic                   o_ack
);
  import mem_bus_pkg::*;

  localparam int DEPTH = 2 ** ADDR_W;

  // Storage, contents unknown until written
  bus_byte_t mem [DEPTH];

  // Ack trails the request by one cycle
  always_ff @(posedge i_clk) begin
    o_ack <= i_req;
  end

  // Read-before-write, so a write hands back the old byte
  always_ff @(posedge i_clk) begin
    if (i_req) begin
      o_rd_byte <= mem[i_addr];
      if (i_write) begin
        mem[i_addr] <= i_wr_byte;
      end
    end
  end

endmodule

//--- hw/byte_sequencer.sv
`timescale 1ns/100ps

module byte_sequencer (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_bus_dv,
  input  mem_bus_pkg::bus_word_t  i_bus_address,
  input  mem_bus_pkg::bus_word_t  i_bus_data,
  input  mem_bus_pkg::size_code_t i_bhw,
  input  logic                    i_write_notread,
  input  mem_bus_pkg::dev_sel_t   i_sel,
  input  logic                    i_boot_ack,
  input  logic                    i_frame_ack,
  input  logic                    i_hex_ack,
  input  logic                    i_test_ack,
  input  mem_bus_pkg::bus_byte_t  i_boot_byte,
  input  mem_bus_pkg::bus_byte_t  i_frame_byte,
  input  mem_bus_pkg::bus_byte_t  i_hex_byte,
  input  mem_bus_pkg::bus_byte_t  i_test_byte,
  output mem_bus_pkg::bus_word_t  o_dev_addr,
  output mem_bus_pkg::bus_byte_t  o_wr_byte,
  output logic                    o_write,
  output logic                    o_boot_req,
  output logic                    o_frame_req,
  output logic                    o_hex_req,
  output logic                    o_test_req,
  output logic                    o_start,
  output mem_bus_pkg::bus_byte_t  o_rd_byte,
  output logic                    o_rd_strobe,
  output logic                    o_bus_dv
);
  import mem_bus_pkg::*;

  seq_state_t state;
  bus_word_t  r_addr;
  bus_word_t  r_wdata;
  size_code_t r_count;
  logic       r_write;
  // Stand-in request/ack pair for unmapped bytes
  logic       r_none_req;
  logic       r_none_ack;
  logic       size_ok;
  logic       any_ack;
  // A request is out this cycle
  logic       req_out;
  // Next request goes out on this edge
  logic       issue;

  assign size_ok = (i_bhw == SIZE_WORD) || (i_bhw == SIZE_HALF) || (i_bhw == SIZE_BYTE);
  assign any_ack = i_boot_ack | i_frame_ack | i_hex_ack | i_test_ack | r_none_ack;
  assign req_out = o_boot_req | o_frame_req | o_hex_req | o_test_req | r_none_req;

  // First byte from ISSUE, later bytes straight off the previous ack
  assign issue = (r_count != '0) &&
                 ((state == SEQ_ISSUE) || ((state == SEQ_WAIT) && any_ack));

  // Accept only while idle, busy pulses are dropped
  assign o_start = i_bus_dv && (state == SEQ_IDLE);

  assign o_dev_addr  = r_addr;
  // Low byte of the shifting write register is always the current one
  assign o_wr_byte   = r_wdata[7:0];
  assign o_write     = r_write;
  assign o_rd_strobe = any_ack;

  // Byte from whichever device answered, zero for unmapped
  always_comb begin
    if (i_boot_ack) begin
      o_rd_byte = i_boot_byte;
    end else if (i_frame_ack) begin
      o_rd_byte = i_frame_byte;
    end else if (i_hex_ack) begin
      o_rd_byte = i_hex_byte;
    end else if (i_test_ack) begin
      o_rd_byte = i_test_byte;
    end else begin
      o_rd_byte = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    // Strobes default low, one cycle each
    o_boot_req  <= 1'b0;
    o_frame_req <= 1'b0;
    o_hex_req   <= 1'b0;
    o_test_req  <= 1'b0;
    r_none_req  <= 1'b0;
    o_bus_dv    <= 1'b0;
    r_none_ack  <= r_none_req;
    if (i_reset) begin
      state      <= SEQ_IDLE;
      r_count    <= '0;
      r_write    <= 1'b0;
      r_none_ack <= 1'b0;
    end else begin
      if (issue) begin
        // Request goes to the device the map picked
        case (i_sel)
          DEV_BOOT:  o_boot_req  <= 1'b1;
          DEV_FRAME: o_frame_req <= 1'b1;
          DEV_HEX:   o_hex_req   <= 1'b1;
          DEV_TEST:  o_test_req  <= 1'b1;
          default:   r_none_req  <= 1'b1;
        endcase
      end
      case (state)
        SEQ_IDLE: begin
          if (o_start) begin
            r_addr  <= i_bus_address;
            r_wdata <= i_bus_data;
            r_write <= i_write_notread;
            // Bad size means zero bytes, finishes straight from ISSUE
            r_count <= size_ok ? i_bhw : '0;
            state   <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          if (r_count == '0) begin
            o_bus_dv <= 1'b1;
            state    <= SEQ_IDLE;
          end else begin
            state <= SEQ_WAIT;
          end
        end
        SEQ_WAIT: begin
          if (req_out) begin
            // Device latched this byte, step on to the next one
            r_addr  <= r_addr + 32'd1;
            r_wdata <= r_wdata >> 8;
            r_count <= r_count - 3'd1;
          end else if (any_ack && (r_count == '0)) begin
            // Last byte done
            o_bus_dv <= 1'b1;
            state    <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

//--- hw/hex_display_regs.sv
`timescale 1ns/100ps

module hex_display_regs (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic [1:0]             i_addr,
  input  mem_bus_pkg::bus_byte_t i_wr_byte,
  input  logic                   i_write,
  input  logic                   i_req,
  output mem_bus_pkg::bus_byte_t o_rd_byte,
  output logic                   o_ack,
  output mem_bus_pkg::bus_word_t o_hex
);
  import mem_bus_pkg::*;

  bus_byte_t regs [4];

  // Byte k sits in bits 8k+7..8k
  assign o_hex = {regs[3], regs[2], regs[1], regs[0]};

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ack <= 1'b0;
      for (int k = 0; k < 4; k++) begin
        regs[k] <= '0;
      end
    end else begin
      o_ack <= i_req;
      if (i_req && i_write) begin
        regs[i_addr] <= i_wr_byte;
      end
    end
  end

  // Old value goes back with the ack
  always_ff @(posedge i_clk) begin
    if (i_req) begin
      o_rd_byte <= regs[i_addr];
    end
  end

endmodule

//--- hw/mem_addr_decoder.sv
`timescale 1ns/100ps

module mem_addr_decoder (
  input  mem_bus_pkg::bus_word_t i_addr,
  output mem_bus_pkg::dev_sel_t  o_sel
);
  import mem_bus_pkg::*;

  logic in_boot;
  logic in_frame;
  logic in_hex;
  logic in_test;

  // True when addr falls in [base, base + size)
  // Offset wraps for addresses below base, so one compare is enough
  function automatic logic in_window(
    input bus_word_t addr,
    input bus_word_t base,
    input bus_word_t size
  );
    bus_word_t offset;
    offset = addr - base;
    return offset < size;
  endfunction

  assign in_boot  = in_window(i_addr, BOOT_BASE, BOOT_SIZE);
  assign in_frame = in_window(i_addr, FRAME_BASE, FRAME_SIZE);
  assign in_hex   = in_window(i_addr, HEX_BASE, HEX_SIZE);
  assign in_test  = in_window(i_addr, TEST_BASE, TEST_SIZE);

  // Windows do not overlap, order only matters for readability
  always_comb begin
    if (in_boot) begin
      o_sel = DEV_BOOT;
    end else if (in_frame) begin
      o_sel = DEV_FRAME;
    end else if (in_hex) begin
      o_sel = DEV_HEX;
    end else if (in_test) begin
      o_sel = DEV_TEST;
    end else begin
      // Unmapped hole
      o_sel = DEV_NONE;
    end
  end

endmodule

//--- hw/mem_bus_pkg.sv
package mem_bus_pkg;

  // Bus word, used for both data and addresses
  typedef logic [31:0] bus_word_t;
  // One byte moved to or from a device
  typedef logic [7:0] bus_byte_t;
  // Size code from the CPU side
  typedef logic [2:0] size_code_t;
  // Test-pass flag vector
  typedef logic [63:0] test_pass_t;

  // Size codes equal their byte counts
  localparam size_code_t SIZE_WORD = 3'd4;
  localparam size_code_t SIZE_HALF = 3'd2;
  localparam size_code_t SIZE_BYTE = 3'd1;

  // RAM address widths
  localparam int BOOT_ADDR_W  = 12;
  localparam int FRAME_ADDR_W = 10;

  // Memory map windows
  localparam bus_word_t BOOT_BASE  = 32'h0000_0000;
  localparam bus_word_t BOOT_SIZE  = 32'd4096;
  localparam bus_word_t FRAME_BASE = 32'h0001_0000;
  localparam bus_word_t FRAME_SIZE = 32'd1024;
  localparam bus_word_t HEX_BASE   = 32'h0002_0000;
  localparam bus_word_t HEX_SIZE   = 32'd4;
  localparam bus_word_t TEST_BASE  = 32'h0003_0000;
  localparam bus_word_t TEST_SIZE  = 32'd8;

  // Device picked by the address map
  typedef enum logic [2:0] {
    DEV_NONE,
    DEV_BOOT,
    DEV_FRAME,
    DEV_HEX,
    DEV_TEST
  } dev_sel_t;

  // Byte sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT
  } seq_state_t;

endpackage

//--- hw/mem_bus_top.sv
`timescale 1ns/100ps

module mem_bus_top (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic                    i_bus_dv,
  input  mem_bus_pkg::bus_word_t  i_bus_address,
  input  mem_bus_pkg::bus_word_t  i_bus_data,
  input  mem_bus_pkg::size_code_t i_bhw,
  input  logic                    i_write_notread,
  output mem_bus_pkg::bus_word_t  o_bus_data,
  output logic                    o_bus_dv,
  output mem_bus_pkg::bus_word_t  o_hex,
  output mem_bus_pkg::test_pass_t o_test_pass
);
  import mem_bus_pkg::*;

  // Sequencer to devices
  bus_word_t dev_addr;
  bus_byte_t wr_byte;
  logic      write;
  logic      boot_req;
  logic      frame_req;
  logic      hex_req;
  logic      test_req;
  dev_sel_t  sel;
  // Device answers
  logic      boot_ack;
  logic      frame_ack;
  logic      hex_ack;
  logic      test_ack;
  bus_byte_t boot_byte;
  bus_byte_t frame_byte;
  bus_byte_t hex_byte;
  bus_byte_t test_byte;
  // Sequencer to assembler
  logic      start;
  bus_byte_t rd_byte;
  logic      rd_strobe;

  mem_addr_decoder decoder (
    .i_addr (dev_addr),
    .o_sel  (sel)
  );

  byte_sequencer sequencer (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_bus_dv        (i_bus_dv),
    .i_bus_address   (i_bus_address),
    .i_bus_data      (i_bus_data),
    .i_bhw           (i_bhw),
    .i_write_notread (i_write_notread),
    .i_sel           (sel),
    .i_boot_ack      (boot_ack),
    .i_frame_ack     (frame_ack),
    .i_hex_ack       (hex_ack),
    .i_test_ack      (test_ack),
    .i_boot_byte     (boot_byte),
    .i_frame_byte    (frame_byte),
    .i_hex_byte      (hex_byte),
    .i_test_byte     (test_byte),
    .o_dev_addr      (dev_addr),
    .o_wr_byte       (wr_byte),
    .o_write         (write),
    .o_boot_req      (boot_req),
    .o_frame_req     (frame_req),
    .o_hex_req       (hex_req),
    .o_test_req      (test_req),
    .o_start         (start),
    .o_rd_byte       (rd_byte),
    .o_rd_strobe     (rd_strobe),
    .o_bus_dv        (o_bus_dv)
  );

  read_word_assembler assembler (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_start     (start),
    .i_rd_strobe (rd_strobe),
    .i_rd_byte   (rd_byte),
    .i_write     (write),
    .o_bus_data  (o_bus_data)
  );

  // Each device sees only its low address bits
  byte_ram #(.ADDR_W(BOOT_ADDR_W)) boot_ram (
    .i_clk     (i_clk),
    .i_addr    (dev_addr[BOOT_ADDR_W-1:0]),
    .i_wr_byte (wr_byte),
    .i_write   (write),
    .i_req     (boot_req),
    .o_rd_byte (boot_byte),
    .o_ack     (boot_ack)
  );

  byte_ram #(.ADDR_W(FRAME_ADDR_W)) frame_ram (
    .i_clk     (i_clk),
    .i_addr    (dev_addr[FRAME_ADDR_W-1:0]),
    .i_wr_byte (wr_byte),
    .i_write   (write),
    .i_req     (frame_req),
    .o_rd_byte (frame_byte),
    .o_ack     (frame_ack)
  );

  hex_display_regs hex_regs (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_addr    (dev_addr[1:0]),
    .i_wr_byte (wr_byte),
    .i_write   (write),
    .i_req     (hex_req),
    .o_rd_byte (hex_byte),
    .o_ack     (hex_ack),
    .o_hex     (o_hex)
  );

  test_pass_regs test_regs (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_addr      (dev_addr[2:0]),
    .i_wr_byte   (wr_byte),
    .i_write     (write),
    .i_req       (test_req),
    .o_rd_byte   (test_byte),
    .o_ack       (test_ack),
    .o_test_pass (o_test_pass)
  );

endmodule

//--- hw/read_word_assembler.sv
`timescale 1ns/100ps

module read_word_assembler (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_start,
  input  logic                   i_rd_strobe,
  input  mem_bus_pkg::bus_byte_t i_rd_byte,
  input  logic                   i_write,
  output mem_bus_pkg::bus_word_t o_bus_data
);
  import mem_bus_pkg::*;

  bus_word_t  r_word;
  // Next byte lane to fill
  logic [1:0] r_lane;

  assign o_bus_data = r_word;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      r_word <= '0;
      r_lane <= '0;
    end else if (i_start) begin
      // New transaction, unused lanes stay zero
      r_word <= '0;
      r_lane <= '0;
    end else if (i_rd_strobe) begin
      // Writes step the lane but leave the word alone
      if (!i_write) begin
        r_word[r_lane*8 +: 8] <= i_rd_byte;
      end
      r_lane <= r_lane + 2'd1;
    end
  end

endmodule

//--- hw/test_pass_regs.sv
`timescale 1ns/100ps

module test_pass_regs (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  logic [2:0]              i_addr,
  input  mem_bus_pkg::bus_byte_t  i_wr_byte,
  input  logic                    i_write,
  input  logic                    i_req,
  output mem_bus_pkg::bus_byte_t  o_rd_byte,
  output logic                    o_ack,
  output mem_bus_pkg::test_pass_t o_test_pass
);
  import mem_bus_pkg::*;

  bus_byte_t regs [8];

  // Little-endian, byte 0 in the low bits
  assign o_test_pass = {regs[7], regs[6], regs[5], regs[4],
                        regs[3], regs[2], regs[1], regs[0]};

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ack <= 1'b0;
      for (int k = 0; k < 8; k++) begin
        regs[k] <= '0;
      end
    end else begin
      o_ack <= i_req;
      if (i_req && i_write) begin
        regs[i_addr] <= i_wr_byte;
      end
    end
  end

  // Readback of the stored flags
  always_ff @(posedge i_clk) begin
    if (i_req) begin
      o_rd_byte <= regs[i_addr];
    end
  end

endmodule

//--- tests/mem_bus_tb.sv
`timescale 1ns/100ps

module mem_bus_tb;
  import mem_bus_pkg::*;

  // One table row, data is drawn from the generator when rnd is set
  typedef struct packed {
    bus_word_t  addr;
    size_code_t bhw;
    logic       wr;
    logic       rnd;
    bus_word_t  data;
    logic       use_exp;
    bus_word_t  exp_word;
  } txn_t;

  logic       i_clk = 1'b0;
  logic       i_reset;
  logic       i_bus_dv;
  bus_word_t  i_bus_address;
  bus_word_t  i_bus_data;
  size_code_t i_bhw;
  logic       i_write_notread;
  bus_word_t  o_bus_data;
  logic       o_bus_dv;
  bus_word_t  o_hex;
  test_pass_t o_test_pass;

  txn_t      txn_q [$];
  bus_word_t rng_state;
  int        budget_cycles = 0;
  // Reference copies of the four windows
  bus_byte_t boot_model [2**BOOT_ADDR_W];
  bus_byte_t frame_model [2**FRAME_ADDR_W];
  bus_byte_t hex_model [4];
  bus_byte_t test_model [8];

  mem_bus_top mem_bus_top_i (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_bus_dv        (i_bus_dv),
    .i_bus_address   (i_bus_address),
    .i_bus_data      (i_bus_data),
    .i_bhw           (i_bhw),
    .i_write_notread (i_write_notread),
    .o_bus_data      (o_bus_data),
    .o_bus_dv        (o_bus_dv),
    .o_hex           (o_hex),
    .o_test_pass     (o_test_pass)
  );

  // 4 ns period
  always #2 i_clk = ~i_clk;

  function automatic bus_word_t xorshift32(input bus_word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Byte count of a size code, zero when invalid
  function automatic int size_bytes(input size_code_t bhw);
    if (bhw == SIZE_WORD) return 4;
    if (bhw == SIZE_HALF) return 2;
    if (bhw == SIZE_BYTE) return 1;
    return 0;
  endfunction

  // Unmapped bytes read as zero
  function automatic bus_byte_t model_read(input bus_word_t addr);
    if ((addr - BOOT_BASE) < BOOT_SIZE) return boot_model[addr - BOOT_BASE];
    if ((addr - FRAME_BASE) < FRAME_SIZE) return frame_model[addr - FRAME_BASE];
    if ((addr - HEX_BASE) < HEX_SIZE) return hex_model[addr - HEX_BASE];
    if ((addr - TEST_BASE) < TEST_SIZE) return test_model[addr - TEST_BASE];
    return 8'h00;
  endfunction

  // Byte k at addr+k, the rest of the word zero
  function automatic bus_word_t model_word(input bus_word_t addr, input int nbytes);
    bus_word_t w;
    w = '0;
    for (int k = 0; k < nbytes; k++) begin
      w[8*k +: 8] = model_read(addr + k);
    end
    return w;
  endfunction

  // Write rule, unmapped bytes dropped
  task automatic model_store(input bus_word_t addr, input int nbytes, input bus_word_t data);
    bus_word_t a;
    for (int k = 0; k < nbytes; k++) begin
      a = addr + k;
      if ((a - BOOT_BASE) < BOOT_SIZE) boot_model[a - BOOT_BASE] = data[8*k +: 8];
      else if ((a - FRAME_BASE) < FRAME_SIZE) frame_model[a - FRAME_BASE] = data[8*k +: 8];
      else if ((a - HEX_BASE) < HEX_SIZE) hex_model[a - HEX_BASE] = data[8*k +: 8];
      else if ((a - TEST_BASE) < TEST_SIZE) test_model[a - TEST_BASE] = data[8*k +: 8];
    end
  endtask

  function automatic test_pass_t model_test_flags();
    test_pass_t t;
    for (int k = 0; k < 8; k++) begin
      t[8*k +: 8] = test_model[k];
    end
    return t;
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_word(input string what, input bus_word_t got, input bus_word_t exp_w);
    if (got !== exp_w) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp_w);
      abort_run();
    end
  endtask

  task automatic check_hex(input string what, input bus_word_t got, input bus_word_t exp_w);
    if (got !== exp_w) begin
      $display("ERR %0t: %s o_hex %h expected %h", $time, what, got, exp_w);
      abort_run();
    end
  endtask

  task automatic check_test(input string what, input test_pass_t got, input test_pass_t exp_t);
    if (got !== exp_t) begin
      $display("ERR %0t: %s o_test_pass %h expected %h", $time, what, got, exp_t);
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp_f);
    if (got !== exp_f) begin
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp_f);
      abort_run();
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp_c);
    if (got != exp_c) begin
      $display("ERR %0t: %s took %0d cycles expected %0d", $time, what, got, exp_c);
      abort_run();
    end
  endtask

  function automatic txn_t make_txn(input bus_word_t addr, input size_code_t bhw,
                                    input logic wr, input logic rnd, input bus_word_t data,
                                    input logic use_exp, input bus_word_t exp_word);
    txn_t t;
    t.addr     = addr;
    t.bhw      = bhw;
    t.wr       = wr;
    t.rnd      = rnd;
    t.data     = data;
    t.use_exp  = use_exp;
    t.exp_word = exp_word;
    return t;
  endfunction

  task automatic add_write(input bus_word_t addr, input size_code_t bhw, input logic rnd,
                           input bus_word_t data);
    txn_q.push_back(make_txn(addr, bhw, 1'b1, rnd, data, 1'b0, '0));
  endtask

  // use_exp picks the literal, otherwise the model gives the word
  task automatic add_read(input bus_word_t addr, input size_code_t bhw, input logic use_exp,
                          input bus_word_t exp_word);
    txn_q.push_back(make_txn(addr, bhw, 1'b0, 1'b0, '0, use_exp, exp_word));
  endtask

  task automatic load_table();
    // Boot RAM, aligned and straddling
    add_write(32'h0000_0000, SIZE_WORD, 1'b0, 32'h1357_9BDF);
    add_write(32'h0000_0010, SIZE_WORD, 1'b1, '0);
    add_read(32'h0000_0010, SIZE_WORD, 1'b0, '0);
    add_write(32'h0000_0021, SIZE_HALF, 1'b1, '0);
    add_read(32'h0000_0021, SIZE_HALF, 1'b0, '0);
    add_write(32'h0000_0033, SIZE_BYTE, 1'b0, 32'hDEAD_BEA5);
    add_read(32'h0000_0033, SIZE_BYTE, 1'b1, 32'h0000_00A5);
    add_write(32'h0000_0101, SIZE_WORD, 1'b1, '0);
    add_read(32'h0000_0102, SIZE_HALF, 1'b0, '0);
    // Last two bytes fall past the boot window
    add_write(32'h0000_0FFE, SIZE_WORD, 1'b1, '0);
    add_read(32'h0000_0FFE, SIZE_WORD, 1'b0, '0);
    add_write(32'h0000_0200, SIZE_WORD, 1'b0, 32'h1122_3344);
    // Frame RAM
    add_write(32'h0001_0000, SIZE_WORD, 1'b1, '0);
    add_read(32'h0001_0000, SIZE_WORD, 1'b0, '0);
    add_write(32'h0001_03FF, SIZE_HALF, 1'b1, '0);
    add_read(32'h0001_03FF, SIZE_HALF, 1'b0, '0);
    add_write(32'h0001_0005, SIZE_BYTE, 1'b0, 32'h0000_005A);
    add_read(32'h0001_0005, SIZE_BYTE, 1'b1, 32'h0000_005A);
    // Hex registers
    add_write(32'h0002_0000, SIZE_WORD, 1'b0, 32'h8765_4321);
    add_read(32'h0002_0000, SIZE_WORD, 1'b1, 32'h8765_4321);
    add_write(32'h0002_0001, SIZE_HALF, 1'b1, '0);
    add_read(32'h0002_0000, SIZE_WORD, 1'b0, '0);
    add_write(32'h0002_0003, SIZE_BYTE, 1'b1, '0);
    add_write(32'h0002_0002, SIZE_WORD, 1'b1, '0);
    add_read(32'h0002_0002, SIZE_WORD, 1'b0, '0);
    // Test-pass registers, upper word first
    add_write(32'h0003_0004, SIZE_WORD, 1'b1, '0);
    add_read(32'h0003_0004, SIZE_WORD, 1'b0, '0);
    add_write(32'h0003_0000, SIZE_WORD, 1'b0, 32'hCAFE_F00D);
    add_read(32'h0003_0000, SIZE_HALF, 1'b1, 32'h0000_F00D);
    add_write(32'h0003_0007, SIZE_BYTE, 1'b1, '0);
    // Unmapped holes, low bits match every window base
    add_write(32'h0000_5000, SIZE_WORD, 1'b1, '0);
    add_read(32'h0000_5000, SIZE_WORD, 1'b1, '0);
    add_write(32'h0004_0000, SIZE_WORD, 1'b1, '0);
    add_read(32'h0004_0000, SIZE_WORD, 1'b1, '0);
    add_read(32'hFFFF_FFFF, SIZE_BYTE, 1'b1, '0);
    // Invalid size codes
    add_write(32'h0002_0000, 3'd3, 1'b1, '0);
    add_read(32'h0000_0010, 3'd0, 1'b1, '0);
    add_read(32'h0003_0000, 3'd7, 1'b1, '0);
    // Every window still matches the model
    add_read(32'h0000_0000, SIZE_WORD, 1'b0, '0);
    add_read(32'h0001_0000, SIZE_WORD, 1'b0, '0);
    add_read(32'h0002_0000, SIZE_WORD, 1'b0, '0);
    add_read(32'h0003_0000, SIZE_WORD, 1'b0, '0);
    add_read(32'h0003_0004, SIZE_WORD, 1'b0, '0);
  endtask

  task automatic drive_bus(input logic dv, input bus_word_t addr, input size_code_t bhw,
                           input logic wr, input bus_word_t data);
    i_bus_dv        = dv;
    i_bus_address   = addr;
    i_bhw           = bhw;
    i_write_notread = wr;
    i_bus_data      = data;
  endtask

  // Pulse spans one rising edge, the accepting one
  task automatic start_txn(input bus_word_t addr, input size_code_t bhw, input logic wr,
                           input bus_word_t data);
    @(negedge i_clk);
    drive_bus(1'b1, addr, bhw, wr, data);
    @(negedge i_clk);
    i_bus_dv = 1'b0;
  endtask

  // Edges after acceptance until o_bus_dv shows
  task automatic wait_done(output int cycles);
    cycles = 0;
    while (o_bus_dv !== 1'b1) begin
      @(negedge i_clk);
      cycles++;
    end
  endtask

  // One cycle to accept, then a request and an ack per byte
  function automatic int expected_latency(input int nbytes);
    return 1 + 2 * nbytes;
  endfunction

  task automatic run_entry(input string tag, input txn_t t);
    bus_word_t data;
    bus_word_t exp_w;
    int        nbytes;
    int        cycles;
    nbytes = size_bytes(t.bhw);
    data   = t.data;
    if (t.rnd) begin
      rng_state = xorshift32(rng_state);
      data      = rng_state;
    end
    // Writes and bad sizes leave the bus word at zero
    if (t.wr || nbytes == 0) begin
      exp_w = '0;
    end else if (t.use_exp) begin
      exp_w = t.exp_word;
    end else begin
      exp_w = model_word(t.addr, nbytes);
    end
    start_txn(t.addr, t.bhw, t.wr, data);
    wait_done(cycles);
    check_latency({tag, " latency"}, cycles, expected_latency(nbytes));
    check_word({tag, " bus data"}, o_bus_data, exp_w);
    if (t.wr) begin
      model_store(t.addr, nbytes, data);
    end
    check_hex(tag, o_hex, {hex_model[3], hex_model[2], hex_model[1], hex_model[0]});
    check_test(tag, o_test_pass, model_test_flags());
  endtask

  // Second pulse lands mid-transaction and must vanish
  task automatic busy_pulse_test();
    bus_word_t first_data;
    int        cycles;
    rng_state  = xorshift32(rng_state);
    first_data = rng_state;
    start_txn(32'h0000_0300, SIZE_WORD, 1'b1, first_data);
    cycles = 0;
    while (o_bus_dv !== 1'b1) begin
      @(negedge i_clk);
      cycles++;
      if (cycles == 3) begin
        drive_bus(1'b1, 32'h0000_0200, SIZE_WORD, 1'b1, 32'hFFFF_FFFF);
      end else begin
        i_bus_dv = 1'b0;
      end
    end
    i_bus_dv = 1'b0;
    check_latency("busy first txn latency", cycles, expected_latency(4));
    check_word("busy first txn bus data", o_bus_data, '0);
    model_store(32'h0000_0300, 4, first_data);
    // No late completion from the dropped pulse
    repeat (16) begin
      @(negedge i_clk);
      check_flag("o_bus_dv after busy txn", o_bus_dv, 1'b0);
    end
    run_entry("busy readback 0x200", make_txn(32'h0000_0200, SIZE_WORD, 1'b0, 1'b0, '0, 1'b0, '0));
    run_entry("busy readback 0x300", make_txn(32'h0000_0300, SIZE_WORD, 1'b0, 1'b0, '0, 1'b0, '0));
  endtask

  initial begin
    drive_bus(1'b0, '0, SIZE_WORD, 1'b0, '0);
    i_reset   = 1'b1;
    rng_state = 32'd89;
    // RAM models stay unknown until written, registers reset to zero
    for (int k = 0; k < 4; k++) begin
      hex_model[k] = 8'h00;
    end
    for (int k = 0; k < 8; k++) begin
      test_model[k] = 8'h00;
    end
    load_table();
    // Up to 12 cycles per entry, plus reset and the busy test
    budget_cycles = txn_q.size() * 12 + 50;
    repeat (10) @(negedge i_clk);
    i_reset = 1'b0;
    @(negedge i_clk);
    check_hex("after reset", o_hex, '0);
    check_test("after reset", o_test_pass, '0);
    check_word("o_bus_data after reset", o_bus_data, '0);
    check_flag("o_bus_dv after reset", o_bus_dv, 1'b0);
    for (int i = 0; i < txn_q.size(); i++) begin
      run_entry($sformatf("entry %0d", i), txn_q[i]);
    end
    busy_pulse_test();
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Watchdog
  initial begin
    wait (budget_cycles > 0);
    repeat (budget_cycles) @(posedge i_clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", budget_cycles);
    abort_run();
  end

endmodule
